// ==== source/proc_config.svh ====
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// data path width, address and instruction
`define XLEN            32

// icache geometry, one line is 64 bits or two instructions
`define ICACHE_LINES    16

// branch target buffer size
`define BTB_ENTRIES     8

// wfi encoding, system opcode with funct12 = 0x105
`define WFI_INST        32'h10500073

`endif

// ==== source/proc_pkg.sv ====
`include "proc_config.svh"

package proc_pkg;

    // memory bus command
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2            // unused by the front end
    } mem_command_t;

    // access size on the memory port
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3               // full cache line
    } mem_size_t;

    // status codes, same values as the riscv mcause set
    typedef enum logic [3:0] {
        ILLEGAL_INST  = 4'h2,
        NO_ERROR      = 4'ha,
        HALTED_ON_WFI = 4'he
    } exception_code_t;

    // one fetched instruction headed for decode
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [31:0]       inst;
        logic              pred_taken;   // btb said taken
        logic [`XLEN-1:0]  pred_target;
    } fetch_packet_t;

    // resolved branch coming back from execute
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic              taken;
        logic [`XLEN-1:0]  target;
        logic              mis_pred;     // redirect fetch
    } branch_result_t;

    // btb lookup result
    typedef struct packed {
        logic              taken;
        logic [`XLEN-1:0]  target;
    } prediction_t;

endpackage

// ==== source/icache.sv ====
`include "proc_config.svh"

module icache (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic [`XLEN-1:0]        fetch_addr,
    input  logic [3:0]              mem2proc_response,  // request tag, 0 = refused
    input  logic [63:0]             mem2proc_data,
    input  logic [3:0]              mem2proc_tag,       // tag of returning data
    output logic [31:0]             inst,
    output logic                    inst_valid,
    output proc_pkg::mem_command_t  proc2mem_command,
    output logic [`XLEN-1:0]        proc2mem_addr
);
    import proc_pkg::*;

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `XLEN - IDX_W - 3;   // 8 bytes per line

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_TAG
    } refill_state_t;

    // line storage
    logic [63:0]              line_data [`ICACHE_LINES];
    logic [TAG_W-1:0]         line_tag  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    logic [IDX_W-1:0]  rd_idx;
    logic [TAG_W-1:0]  rd_tag;
    logic              hit;

    refill_state_t     state;
    refill_state_t     state_nxt;
    logic [`XLEN-1:0]  miss_addr;   // line aligned refill address
    logic [3:0]        miss_tag;    // bus tag of the refill in flight
    logic              fill;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign rd_idx = fetch_addr[IDX_W+2:3];
    assign rd_tag = fetch_addr[`XLEN-1:IDX_W+3];
    assign hit    = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

    // bit 2 picks the upper word
    assign inst       = fetch_addr[2] ? line_data[rd_idx][63:32] : line_data[rd_idx][31:0];
    assign inst_valid = hit;

    //////////////////////////////////////////////////
    // refill state machine
    //////////////////////////////////////////////////

    // data back for our request
    assign fill = (state == WAIT_TAG) && (mem2proc_tag == miss_tag);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!hit) state_nxt = REQUEST;
            end
            REQUEST: begin
                if (mem2proc_response != 4'd0) state_nxt = WAIT_TAG;   // accepted
            end
            WAIT_TAG: begin
                if (fill) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // refill address and bus tag
    always_ff @(posedge clock) begin
        if (state == IDLE && !hit) begin
            miss_addr <= {fetch_addr[`XLEN-1:3], 3'b000};
        end
        if (state == REQUEST && mem2proc_response != 4'd0) begin
            miss_tag <= mem2proc_response;
        end
    end

    // line write, completes even if fetch moved on
    always_ff @(posedge clock) begin
        if (fill) begin
            line_data[miss_addr[IDX_W+2:3]] <= mem2proc_data;
            line_tag[miss_addr[IDX_W+2:3]]  <= miss_addr[`XLEN-1:IDX_W+3];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (fill) begin
            line_valid[miss_addr[IDX_W+2:3]] <= 1'b1;
        end
    end

    // load held until memory gives a nonzero tag
    assign proc2mem_command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
    assign proc2mem_addr    = (state == REQUEST) ? miss_addr : '0;

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // accepted request goes quiet while waiting for data
    a_quiet_after_accept : assert property (@(posedge clock) disable iff (!arst_n)
        (proc2mem_command == BUS_LOAD && mem2proc_response != 4'd0)
            |=> proc2mem_command == BUS_NONE)
        else $error("icache: command not BUS_NONE while waiting for tag");

    a_line_aligned : assert property (@(posedge clock) disable iff (!arst_n)
        proc2mem_command == BUS_LOAD |-> proc2mem_addr[2:0] == 3'b000)
        else $error("icache: unaligned refill address %h", proc2mem_addr);

endmodule

// ==== source/branch_predictor.sv ====
`include "proc_config.svh"

module branch_predictor (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [`XLEN-1:0]         lookup_pc,
    input  proc_pkg::branch_result_t branch_result,
    output proc_pkg::prediction_t    prediction
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `XLEN - IDX_W - 2;   // word aligned pcs

    // btb storage
    logic [`BTB_ENTRIES-1:0] btb_valid;
    logic [TAG_W-1:0]        btb_tag     [`BTB_ENTRIES];
    logic [`XLEN-1:0]        btb_target  [`BTB_ENTRIES];
    logic [1:0]              btb_counter [`BTB_ENTRIES];   // 2-bit saturating

    logic [IDX_W-1:0]  lk_idx;
    logic [TAG_W-1:0]  lk_tag;
    logic              lk_hit;

    logic [IDX_W-1:0]  tr_idx;
    logic [TAG_W-1:0]  tr_tag;
    logic              tr_hit;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign lk_idx = lookup_pc[IDX_W+1:2];
    assign lk_tag = lookup_pc[`XLEN-1:IDX_W+2];
    assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

    // taken only on a hit with counter in the upper half
    assign prediction.taken  = lk_hit && btb_counter[lk_idx][1];
    assign prediction.target = lk_hit ? btb_target[lk_idx] : '0;

    //////////////////////////////////////////////////
    // training
    //////////////////////////////////////////////////

    assign tr_idx = branch_result.pc[IDX_W+1:2];
    assign tr_tag = branch_result.pc[`XLEN-1:IDX_W+2];
    assign tr_hit = btb_valid[tr_idx] && (btb_tag[tr_idx] == tr_tag);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            btb_valid <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btb_counter[i] <= 2'b01;   // weakly not taken
            end
        end else if (branch_result.valid) begin
            if (branch_result.taken) begin
                btb_valid[tr_idx] <= 1'b1;
                if (!tr_hit) begin
                    btb_counter[tr_idx] <= 2'b10;   // fresh entry, weakly taken
                end else if (btb_counter[tr_idx] != 2'b11) begin
                    btb_counter[tr_idx] <= btb_counter[tr_idx] + 2'd1;
                end
            end else if (tr_hit && btb_counter[tr_idx] != 2'b00) begin
                btb_counter[tr_idx] <= btb_counter[tr_idx] - 2'd1;
            end
        end
    end

    // tag and target only move on a taken result
    always_ff @(posedge clock) begin
        if (branch_result.valid && branch_result.taken) begin
            btb_tag[tr_idx]    <= tr_tag;
            btb_target[tr_idx] <= branch_result.target;
        end
    end

    // taken target must come from a trained entry, always word aligned
    a_taken_from_valid : assert property (@(posedge clock) disable iff (!arst_n)
        prediction.taken |-> btb_valid[lk_idx] && prediction.target[1:0] == 2'b00)
        else $error("btb: taken prediction %h from bad entry %0d",
                    prediction.target, lk_idx);

endmodule

// ==== source/fetch_stage.sv ====
`include "proc_config.svh"

module fetch_stage (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [31:0]              inst,
    input  logic                     inst_valid,        // icache hit this cycle
    input  proc_pkg::prediction_t    prediction,
    input  logic                     stall,             // back end full
    input  proc_pkg::branch_result_t branch_result,
    output logic [`XLEN-1:0]         fetch_addr,
    output proc_pkg::fetch_packet_t  fetch_packet,
    output logic                     halted
);

    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  pc_nxt;
    logic              redirect;
    logic              fire;
    logic              is_wfi;

    assign redirect = branch_result.valid && branch_result.mis_pred;
    assign fire     = inst_valid && !stall && !halted;
    assign is_wfi   = (inst == `WFI_INST);

    assign fetch_addr = pc;

    //////////////////////////////////////////////////
    // next pc
    //////////////////////////////////////////////////

    // redirect beats prediction beats sequential
    always_comb begin
        pc_nxt = pc;                      // hold on stall, miss or halt
        if (redirect) begin
            pc_nxt = branch_result.target;
        end else if (fire) begin
            pc_nxt = prediction.taken ? prediction.target : pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_nxt;
        end
    end

    // sticky until the back end redirects
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (redirect) begin
            halted <= 1'b0;
        end else if (fire && is_wfi) begin
            halted <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // packet register
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fetch_packet <= '0;
        end else if (redirect) begin
            fetch_packet.valid <= 1'b0;          // squash wrong path
        end else if (!stall) begin
            fetch_packet.valid <= fire;          // bubble on miss or halt
            if (fire) begin
                fetch_packet.pc          <= pc;
                fetch_packet.inst        <= inst;
                fetch_packet.pred_taken  <= prediction.taken;
                fetch_packet.pred_target <= prediction.target;
            end
        end
    end

    a_pc_aligned : assert property (@(posedge clock) disable iff (!arst_n)
        fetch_packet.valid |-> fetch_packet.pc[1:0] == 2'b00)
        else $error("fetch: misaligned packet pc %h", fetch_packet.pc);

endmodule

// ==== source/processor.sv ====
`include "proc_config.svh"

module processor (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [3:0]                mem2proc_response,  // tag for current request
    input  logic [63:0]               mem2proc_data,
    input  logic [3:0]                mem2proc_tag,       // tag for current reply
    input  logic                      stall,
    input  proc_pkg::branch_result_t  branch_result,      // from the back end
    output proc_pkg::mem_command_t    proc2mem_command,
    output logic [`XLEN-1:0]          proc2mem_addr,
    output proc_pkg::mem_size_t       proc2mem_size,
    output proc_pkg::fetch_packet_t   fetch_packet,
    output proc_pkg::exception_code_t processor_error_status
);
    import proc_pkg::*;

    // fetch to icache
    logic [`XLEN-1:0]  fetch_addr;
    logic [31:0]       inst;
    logic              inst_valid;

    prediction_t       prediction;   // btb to fetch
    logic              halted;

    assign proc2mem_size          = DOUBLE;   // whole line per refill
    assign processor_error_status = halted ? HALTED_ON_WFI : NO_ERROR;

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////

    fetch_stage fetch_stage0 (
        .clock         (clock),
        .arst_n        (arst_n),
        .inst          (inst),
        .inst_valid    (inst_valid),
        .prediction    (prediction),
        .stall         (stall),
        .branch_result (branch_result),
        .fetch_addr    (fetch_addr),
        .fetch_packet  (fetch_packet),
        .halted        (halted)
    );

    //////////////////////////////////////////////////
    // icache and predictor
    //////////////////////////////////////////////////

    icache icache0 (
        .clock             (clock),
        .arst_n            (arst_n),
        .fetch_addr        (fetch_addr),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag),
        .inst              (inst),
        .inst_valid        (inst_valid),
        .proc2mem_command  (proc2mem_command),   // icache owns the bus
        .proc2mem_addr     (proc2mem_addr)
    );

    branch_predictor branch_predictor0 (
        .clock         (clock),
        .arst_n        (arst_n),
        .lookup_pc     (fetch_addr),     // same pc the icache sees
        .branch_result (branch_result),
        .prediction    (prediction)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic clock,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    // release lands between rising edges
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// ==== bench/tb_processor.sv ====
`include "proc_config.svh"

module tb_processor;
    timeunit 1ns;
    timeprecision 100ps;

    import proc_pkg::*;

    // about 70 refills of up to ~20 cycles each with stalls plus margin
    localparam int MAX_CYCLES = 6000;

    logic              clock;
    logic              arst_n;
    logic [3:0]        mem2proc_response;
    logic [63:0]       mem2proc_data;
    logic [3:0]        mem2proc_tag;
    logic              stall;
    branch_result_t    branch_result;
    mem_command_t      proc2mem_command;
    logic [`XLEN-1:0]  proc2mem_addr;
    mem_size_t         proc2mem_size;
    fetch_packet_t     fetch_packet;
    exception_code_t   processor_error_status;

    // memory model
    logic [15:0]       lfsr;
    logic [3:0]        next_tag;        // cycles 1..15
    logic [3:0]        pend_tag;
    logic [`XLEN-1:0]  pend_addr;
    logic [3:0]        delay;
    logic              busy;            // one refill in flight

    // packet history for the checks
    fetch_packet_t     fp_q;
    logic              stall_q;
    logic              have_last;
    logic [`XLEN-1:0]  last_pc;
    logic              last_taken;
    logic              redir_pending;
    logic [`XLEN-1:0]  redir_target;
    logic              wfi_seen;
    logic [1:0]        wfi_count;
    logic              seen_jump;       // 0x40 followed by 0x80
    logic              trained;
    logic              new_pkt;
    logic              redirect_in;
    exception_code_t   exp_status;
    int                errors = 0;
    int                cycles = 0;

    tb_clock clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    processor dut0 (
        .clock                  (clock),
        .arst_n                 (arst_n),
        .mem2proc_response      (mem2proc_response),
        .mem2proc_data          (mem2proc_data),
        .mem2proc_tag           (mem2proc_tag),
        .stall                  (stall),
        .branch_result          (branch_result),
        .proc2mem_command       (proc2mem_command),
        .proc2mem_addr          (proc2mem_addr),
        .proc2mem_size          (proc2mem_size),
        .fetch_packet           (fetch_packet),
        .processor_error_status (processor_error_status)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // word at a is a << 5 | 0x13 except wfi at 0x200
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr == 32'h200) return `WFI_INST;
        return (addr << 5) | 32'h13;
    endfunction

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);       // one step per bit
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Verification failed");
        $fatal(1, "check on %s did not hold", name);
    endtask

    task automatic send_result(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target, input logic mis_pred);
        branch_result_t br;
        br.valid    = 1'b1;
        br.pc       = pc;
        br.taken    = taken;
        br.target   = target;
        br.mis_pred = mis_pred;
        @(posedge clock);
        branch_result <= br;
        @(posedge clock);
        branch_result <= '0;              // one cycle strobe
    endtask

    //////////////////////////////////////////////////
    // memory and back end pressure
    //////////////////////////////////////////////////

    always @(posedge clock or negedge arst_n) begin : memory_model
        logic [7:0] r;
        if (!arst_n) begin
            lfsr               = 16'd74;
            mem2proc_response <= 4'd0;
            mem2proc_data     <= '0;
            mem2proc_tag      <= 4'd0;
            stall             <= 1'b0;
            next_tag          <= 4'd1;
            pend_tag          <= 4'd0;
            pend_addr         <= '0;
            delay             <= 4'd0;
            busy              <= 1'b0;
        end else begin
            draw_bits(2, r);
            stall         <= (r[1:0] == 2'b11);   // about one cycle in four
            mem2proc_tag  <= 4'd0;
            mem2proc_data <= '0;
            if (mem2proc_response != 4'd0) begin
                mem2proc_response <= 4'd0;         // cache takes the tag here
            end else if (proc2mem_command == BUS_LOAD && !busy) begin
                draw_bits(1, r);
                if (r[0] == 1'b0) begin            // a 1 refuses
                    mem2proc_response <= next_tag;
                    pend_tag          <= next_tag;
                    pend_addr         <= proc2mem_addr;
                    draw_bits(3, r);
                    delay             <= 4'(r[2:0]) + 4'd2;
                    busy              <= 1'b1;
                    next_tag          <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
            end
            if (busy) begin
                if (delay > 4'd1) begin
                    delay <= delay - 4'd1;
                end else begin
                    mem2proc_tag  <= pend_tag;
                    mem2proc_data <= {mem_word(pend_addr + 32'd4), mem_word(pend_addr)};
                    busy          <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // packet tracking
    //////////////////////////////////////////////////

    assign new_pkt     = fetch_packet.valid && !stall_q;   // loaded at the last edge
    assign redirect_in = branch_result.valid && branch_result.mis_pred;
    assign exp_status  = (wfi_seen || (fetch_packet.valid && fetch_packet.inst == `WFI_INST))
                         ? HALTED_ON_WFI : NO_ERROR;

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fp_q          <= '0;
            stall_q       <= 1'b0;
            have_last     <= 1'b0;
            last_pc       <= '0;
            last_taken    <= 1'b0;
            redir_pending <= 1'b0;
            redir_target  <= '0;
            wfi_seen      <= 1'b0;
            wfi_count     <= 2'd0;
            seen_jump     <= 1'b0;
        end else begin
            fp_q    <= fetch_packet;
            stall_q <= stall;
            if (new_pkt) begin
                have_last     <= 1'b1;
                last_pc       <= fetch_packet.pc;
                last_taken    <= fetch_packet.pred_taken;
                redir_pending <= 1'b0;
                if (fetch_packet.inst == `WFI_INST) begin
                    wfi_seen  <= 1'b1;
                    wfi_count <= wfi_count + 2'd1;
                end
                if (trained && have_last && last_pc == 32'h40 && fetch_packet.pc == 32'h80)
                    seen_jump <= 1'b1;
            end
            if (redirect_in) begin                 // wins over a packet this edge
                redir_pending <= 1'b1;
                redir_target  <= branch_result.target;
                wfi_seen      <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_inst_rule : assert property (@(posedge clock) disable iff (!arst_n)
        fetch_packet.valid |-> fetch_packet.inst == mem_word(fetch_packet.pc))
        else report_mismatch("fetch_packet.inst", $sampled(fetch_packet.inst),
                             mem_word($sampled(fetch_packet.pc)));

    a_stall_hold : assert property (@(posedge clock) disable iff (!arst_n)
        stall && !redirect_in |=> $stable(fetch_packet))
        else report_mismatch("fetch_packet", $sampled(fetch_packet), $sampled(fp_q));

    a_seq_pc : assert property (@(posedge clock) disable iff (!arst_n)
        new_pkt && have_last && !redir_pending && !last_taken
            |-> fetch_packet.pc == last_pc + 32'd4)
        else report_mismatch("fetch_packet.pc", $sampled(fetch_packet.pc),
                             $sampled(last_pc) + 32'd4);

    // only the trained branch at 0x40 may predict taken
    a_pred_source : assert property (@(posedge clock) disable iff (!arst_n)
        new_pkt && fetch_packet.pred_taken |-> fetch_packet.pc == 32'h40)
        else report_mismatch("fetch_packet.pc", $sampled(fetch_packet.pc), 32'h40);

    a_redirect_pc : assert property (@(posedge clock) disable iff (!arst_n)
        new_pkt && redir_pending |-> fetch_packet.pc == redir_target)
        else report_mismatch("fetch_packet.pc", $sampled(fetch_packet.pc),
                             $sampled(redir_target));

    // trained btb entry at 0x40
    a_btb_taken : assert property (@(posedge clock) disable iff (!arst_n)
        new_pkt && trained && fetch_packet.pc == 32'h40
            |-> fetch_packet.pred_taken && fetch_packet.pred_target == 32'h80)
        else report_mismatch("{fetch_packet.pred_taken, fetch_packet.pred_target}",
                             $sampled({fetch_packet.pred_taken, fetch_packet.pred_target}),
                             {1'b1, 32'h80});

    a_btb_jump : assert property (@(posedge clock) disable iff (!arst_n)
        new_pkt && trained && have_last && !redir_pending && last_pc == 32'h40
            |-> fetch_packet.pc == 32'h80)
        else report_mismatch("fetch_packet.pc", $sampled(fetch_packet.pc), 32'h80);

    a_status : assert property (@(posedge clock) disable iff (!arst_n)
        processor_error_status == exp_status)
        else report_mismatch("processor_error_status", $sampled(processor_error_status),
                             $sampled(exp_status));

    a_halt_quiet : assert property (@(posedge clock) disable iff (!arst_n)
        wfi_seen |-> !new_pkt)
        else report_mismatch("fetch_packet.valid", 1, 0);

    a_line_size : assert property (@(posedge clock) disable iff (!arst_n)
        proc2mem_command == BUS_LOAD |-> proc2mem_size == DOUBLE)
        else report_mismatch("proc2mem_size", $sampled(proc2mem_size), DOUBLE);

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        mem2proc_response = 4'd0;
        mem2proc_data     = '0;
        mem2proc_tag      = 4'd0;
        stall             = 1'b0;
        branch_result     = '0;
        trained           = 1'b0;
        wait (arst_n === 1'b1);
        // two taken results leave the counter strongly taken
        send_result(32'h40, 1'b1, 32'h80, 1'b0);
        send_result(32'h40, 1'b1, 32'h80, 1'b0);
        trained <= 1'b1;
        wait (seen_jump);
        send_result(32'h2c, 1'b0, 32'h30, 1'b1);    // not taken so fetch falls back to 0x30
        wait (wfi_count == 2'd1);
        repeat (20) @(posedge clock);                // halted stretch
        send_result(32'h1f4, 1'b0, 32'h1f8, 1'b1);   // clears halt and runs into wfi again
        wait (wfi_count == 2'd2);
        repeat (10) @(posedge clock);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: fetch did not reach the end of the test in %0d cycles",
                     MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

endmodule

// ==== flist.f ====
+incdir+source
source/proc_pkg.sv
source/icache.sv
source/branch_predictor.sv
source/fetch_stage.sv
source/processor.sv
bench/tb_clock.sv
bench/tb_processor.sv

// ==== Bender.yml ====
package:
  name: proc_frontend

sources:
  - include_dirs:
      - source
    files:
      - source/proc_pkg.sv
      - source/icache.sv
      - source/branch_predictor.sv
      - source/fetch_stage.sv
      - source/processor.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clock.sv
      - bench/tb_processor.sv
